/* include/exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Datapath width
`define EXE_XLEN          32

////////////////////
// Major opcodes
`define EXE_OP_SPECIAL    6'h00   // R-type, decoded by funct
`define EXE_OP_ADDI       6'h08
`define EXE_OP_ADDIU      6'h09
`define EXE_OP_SLTI       6'h0a
`define EXE_OP_SLTIU      6'h0b
`define EXE_OP_ANDI       6'h0c   // Zero-extended immediate
`define EXE_OP_ORI        6'h0d   // Zero-extended immediate
`define EXE_OP_XORI       6'h0e   // Zero-extended immediate
`define EXE_OP_LUI        6'h0f
`define EXE_OP_SPECIAL2   6'h1c   // mul
`define EXE_OP_SPECIAL3   6'h1f   // bshfl

////////////////////
// SPECIAL funct codes
`define EXE_FN_SLL        6'h00
`define EXE_FN_SRL        6'h02   // rotr when rotate bit set
`define EXE_FN_SRA        6'h03
`define EXE_FN_SLLV       6'h04
`define EXE_FN_SRLV       6'h06   // rotrv when rotate bit set
`define EXE_FN_SRAV       6'h07
`define EXE_FN_MFHI       6'h10
`define EXE_FN_MTHI       6'h11
`define EXE_FN_MFLO       6'h12
`define EXE_FN_MTLO       6'h13
`define EXE_FN_MULT       6'h18
`define EXE_FN_MULTU      6'h19
`define EXE_FN_ADD        6'h20
`define EXE_FN_ADDU       6'h21
`define EXE_FN_SUB        6'h22
`define EXE_FN_SUBU       6'h23
`define EXE_FN_AND        6'h24
`define EXE_FN_OR         6'h25
`define EXE_FN_XOR        6'h26
`define EXE_FN_NOR        6'h27
`define EXE_FN_SLT        6'h2a
`define EXE_FN_SLTU       6'h2b

// SPECIAL2 / SPECIAL3
`define EXE_FN2_MUL       6'h02   // Low word only, HI/LO untouched
`define EXE_FN3_BSHFL     6'h20
`define EXE_BSHFL_SEB     5'h10   // Sub-op in the sa field
`define EXE_BSHFL_SEH     5'h18

// Rotate select bits
`define EXE_ROT_BIT       21      // srl -> rotr, rs field lsb
`define EXE_ROTV_BIT      6       // srlv -> rotrv, sa field lsb

`endif

/* logic/exePkg.sv */
`default_nettype none

`include "exe_macros.svh"

package exePkg;

	// Datapath word for operands, results, HI and LO
	typedef logic [`EXE_XLEN-1:0] word_t;

	typedef logic [4:0] shamt_t;  // Shift amount
	typedef logic [5:0] opcode_t; // instr[31:26]
	typedef logic [5:0] funct_t;  // instr[5:0]

	////////////////////
	// ALU operations with fixed 5-bit codes
	typedef enum logic [4:0] {
		ALU_ADD      = 5'd0,
		ALU_SUB      = 5'd1,
		ALU_MULT     = 5'd2,  // Signed 64-bit product
		ALU_AND      = 5'd3,
		ALU_OR       = 5'd4,
		ALU_XOR      = 5'd5,
		ALU_NOR      = 5'd6,
		ALU_SLL      = 5'd7,
		ALU_SRL      = 5'd8,
		ALU_ROTR     = 5'd9,
		ALU_SRA      = 5'd10,
		ALU_SEH      = 5'd11,
		ALU_ADDU     = 5'd12,
		ALU_MULTU    = 5'd13, // Unsigned 64-bit product
		ALU_SLT      = 5'd14,
		ALU_SEB      = 5'd15,
		ALU_SLTU     = 5'd16,
		ALU_SLLV     = 5'd17, // Variable shifts take the whole of a
		ALU_SRLV     = 5'd18,
		ALU_SRAV     = 5'd19,
		ALU_ROTRV    = 5'd20,
		ALU_MOVE     = 5'd21, // Passes operand a
		ALU_RESERVED = 5'd31  // Unknown instruction gives one
	} aluOp_t;

	// What an instruction does to HI/LO
	typedef enum logic [1:0] {
		HILO_NONE,
		HILO_BOTH, // Multiply writes both
		HILO_HI,   // mthi
		HILO_LO    // mtlo
	} hiLoSel_t;

endpackage

`default_nettype wire

/* logic/aluCmdIf.sv */
`timescale 1ns/10ps
`default_nettype none

// One decoded ALU command
interface aluCmdIf;

	exePkg::aluOp_t   op;
	exePkg::word_t    a;
	exePkg::word_t    b;
	exePkg::shamt_t   shamt;   // Fixed shift amount
	exePkg::hiLoSel_t hiLoSel;

	// Decoder builds the command
	modport decoder (output op, output a, output b, output shamt, output hiLoSel);

	// ALU consumes it
	modport alu (input op, input a, input b, input shamt);

	// mthi/mtlo data comes in on operand a
	modport hilo (input hiLoSel, input a);

endinterface

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exe_macros.svh"

module instrDecoder (
	input  wire exePkg::word_t instr,
	input  wire exePkg::word_t rsVal,
	input  wire exePkg::word_t rtVal,
	input  wire exePkg::word_t hi,
	input  wire exePkg::word_t lo,
	aluCmdIf.decoder           cmd
);

	exePkg::opcode_t opcode;
	exePkg::funct_t  funct;
	exePkg::shamt_t  shamt;
	logic [15:0]     imm;
	exePkg::word_t   immSext;
	exePkg::word_t   immZext;

	////////////////////
	// Instruction fields
	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign shamt   = instr[10:6];   // Also the bshfl sub-op
	assign imm     = instr[15:0];
	assign immSext = {{(`EXE_XLEN-16){imm[15]}}, imm};
	assign immZext = {{(`EXE_XLEN-16){1'b0}}, imm}; // Logic immediates

	always_comb begin
		// R-type operands and no HI/LO write unless changed below
		cmd.op      = exePkg::ALU_RESERVED;
		cmd.a       = rsVal;
		cmd.b       = rtVal;
		cmd.shamt   = shamt;
		cmd.hiLoSel = exePkg::HILO_NONE;

		case (opcode)
			`EXE_OP_SPECIAL: begin
				case (funct)
					`EXE_FN_SLL:  cmd.op = exePkg::ALU_SLL;
					`EXE_FN_SRL: begin
						if (instr[`EXE_ROT_BIT])
							cmd.op = exePkg::ALU_ROTR;
						else
							cmd.op = exePkg::ALU_SRL;
					end
					`EXE_FN_SRA:  cmd.op = exePkg::ALU_SRA;
					`EXE_FN_SLLV: cmd.op = exePkg::ALU_SLLV; // rs is the amount
					`EXE_FN_SRLV: begin
						if (instr[`EXE_ROTV_BIT])
							cmd.op = exePkg::ALU_ROTRV;
						else
							cmd.op = exePkg::ALU_SRLV;
					end
					`EXE_FN_SRAV: cmd.op = exePkg::ALU_SRAV;
					`EXE_FN_MFHI: begin
						cmd.op = exePkg::ALU_MOVE;
						cmd.a  = hi;
					end
					`EXE_FN_MFLO: begin
						cmd.op = exePkg::ALU_MOVE;
						cmd.a  = lo;
					end
					`EXE_FN_MTHI: begin
						cmd.op      = exePkg::ALU_MOVE; // rs also shows up as result
						cmd.hiLoSel = exePkg::HILO_HI;
					end
					`EXE_FN_MTLO: begin
						cmd.op      = exePkg::ALU_MOVE;
						cmd.hiLoSel = exePkg::HILO_LO;
					end
					`EXE_FN_MULT: begin
						cmd.op      = exePkg::ALU_MULT;
						cmd.hiLoSel = exePkg::HILO_BOTH;
					end
					`EXE_FN_MULTU: begin
						cmd.op      = exePkg::ALU_MULTU;
						cmd.hiLoSel = exePkg::HILO_BOTH;
					end
					`EXE_FN_ADD:  cmd.op = exePkg::ALU_ADD;  // No overflow trap
					`EXE_FN_ADDU: cmd.op = exePkg::ALU_ADDU;
					`EXE_FN_SUB,
					`EXE_FN_SUBU: cmd.op = exePkg::ALU_SUB;
					`EXE_FN_AND:  cmd.op = exePkg::ALU_AND;
					`EXE_FN_OR:   cmd.op = exePkg::ALU_OR;
					`EXE_FN_XOR:  cmd.op = exePkg::ALU_XOR;
					`EXE_FN_NOR:  cmd.op = exePkg::ALU_NOR;
					`EXE_FN_SLT:  cmd.op = exePkg::ALU_SLT;
					`EXE_FN_SLTU: cmd.op = exePkg::ALU_SLTU;
					default:      cmd.op = exePkg::ALU_RESERVED;
				endcase
			end

			////////////////////
			// I-type forms put the immediate on b
			`EXE_OP_ADDI: begin
				cmd.op = exePkg::ALU_ADD;
				cmd.b  = immSext;
			end
			`EXE_OP_ADDIU: begin
				cmd.op = exePkg::ALU_ADDU;
				cmd.b  = immSext;
			end
			`EXE_OP_SLTI: begin
				cmd.op = exePkg::ALU_SLT;
				cmd.b  = immSext;
			end
			`EXE_OP_SLTIU: begin
				cmd.op = exePkg::ALU_SLTU; // Sign-extended immediate compared unsigned
				cmd.b  = immSext;
			end
			`EXE_OP_ANDI: begin
				cmd.op = exePkg::ALU_AND;
				cmd.b  = immZext;
			end
			`EXE_OP_ORI: begin
				cmd.op = exePkg::ALU_OR;
				cmd.b  = immZext;
			end
			`EXE_OP_XORI: begin
				cmd.op = exePkg::ALU_XOR;
				cmd.b  = immZext;
			end
			`EXE_OP_LUI: begin
				cmd.op = exePkg::ALU_MOVE;
				cmd.a  = {imm, 16'h0000}; // Upper half load
			end

			`EXE_OP_SPECIAL2: begin
				if (funct == `EXE_FN2_MUL)
					cmd.op = exePkg::ALU_MULT; // Low word is the result
			end
			`EXE_OP_SPECIAL3: begin
				// bshfl sub-op sits in the sa field
				if (funct == `EXE_FN3_BSHFL && shamt == `EXE_BSHFL_SEB)
					cmd.op = exePkg::ALU_SEB;
				else if (funct == `EXE_FN3_BSHFL && shamt == `EXE_BSHFL_SEH)
					cmd.op = exePkg::ALU_SEH;
			end
			default: cmd.op = exePkg::ALU_RESERVED;
		endcase
	end

endmodule

`default_nettype wire

/* logic/alu32.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exe_macros.svh"

module alu32 (
	aluCmdIf.alu                cmd,
	output exePkg::word_t       result,
	output exePkg::word_t       hiResult, // Upper product word
	output logic                zero
);

	logic [2*`EXE_XLEN-1:0] prod;     // Full 64-bit product
	logic [5:0]             rotBack;  // Left shift for fixed rotate
	exePkg::word_t          rotBackV; // Left shift for variable rotate

	// Rotate back-shifts that reach 32 at amount zero and clear that half
	assign rotBack  = 6'(`EXE_XLEN) - {1'b0, cmd.shamt};
	assign rotBackV = exePkg::word_t'(`EXE_XLEN) - cmd.a;

	always_comb begin
		prod     = '0;
		hiResult = '0;   // Only multiplies give a high word
		case (cmd.op)
			exePkg::ALU_ADD:  result = cmd.a + cmd.b;
			exePkg::ALU_SUB:  result = cmd.a - cmd.b;
			exePkg::ALU_MULT: begin
				prod = $signed({{`EXE_XLEN{cmd.a[`EXE_XLEN-1]}}, cmd.a}) *
					$signed({{`EXE_XLEN{cmd.b[`EXE_XLEN-1]}}, cmd.b});
				result   = prod[`EXE_XLEN-1:0];
				hiResult = prod[2*`EXE_XLEN-1:`EXE_XLEN];
			end
			exePkg::ALU_AND:  result = cmd.a & cmd.b;
			exePkg::ALU_OR:   result = cmd.a | cmd.b;
			exePkg::ALU_XOR:  result = cmd.a ^ cmd.b;
			exePkg::ALU_NOR:  result = ~(cmd.a | cmd.b);
			exePkg::ALU_SLL:  result = cmd.b << cmd.shamt;
			exePkg::ALU_SRL:  result = cmd.b >> cmd.shamt;
			exePkg::ALU_ROTR: result = (cmd.b >> cmd.shamt) | (cmd.b << rotBack);
			exePkg::ALU_SRA:  result = $signed(cmd.b) >>> cmd.shamt;
			exePkg::ALU_SEH:  result = {{(`EXE_XLEN-16){cmd.b[15]}}, cmd.b[15:0]};
			exePkg::ALU_ADDU: result = cmd.a + cmd.b; // Same sum as add without a trap
			exePkg::ALU_MULTU: begin
				prod     = {{`EXE_XLEN{1'b0}}, cmd.a} * {{`EXE_XLEN{1'b0}}, cmd.b};
				result   = prod[`EXE_XLEN-1:0];
				hiResult = prod[2*`EXE_XLEN-1:`EXE_XLEN];
			end
			exePkg::ALU_SLT:  result = exePkg::word_t'($signed(cmd.a) < $signed(cmd.b));
			exePkg::ALU_SEB:  result = {{(`EXE_XLEN-8){cmd.b[7]}}, cmd.b[7:0]};
			exePkg::ALU_SLTU: result = exePkg::word_t'(cmd.a < cmd.b);

			////////////////////
			// Whole rs value is the amount in the variable forms
			exePkg::ALU_SLLV:  result = cmd.b << cmd.a;  // >= 32 gives zero
			exePkg::ALU_SRLV:  result = cmd.b >> cmd.a;
			exePkg::ALU_SRAV:  result = $signed(cmd.b) >>> cmd.a; // Fills with sign
			exePkg::ALU_ROTRV: result = (cmd.b >> cmd.a) | (cmd.b << rotBackV);
			exePkg::ALU_MOVE:  result = cmd.a;
			default:           result = exePkg::word_t'(1); // Reserved op
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/hiLoRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module hiLoRegs (
	input  wire logic          clk,
	input  wire logic          arstN,
	input  wire logic          accept,    // Instruction taken this edge
	aluCmdIf.hilo              cmd,
	input  wire exePkg::word_t product,   // Low product word
	input  wire exePkg::word_t productHi,
	output exePkg::word_t      hi,
	output exePkg::word_t      lo
);

	// Written at the accept edge, so the next instruction reads the new value
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hi <= '0;
			lo <= '0;
		end else if (accept) begin
			case (cmd.hiLoSel)
				exePkg::HILO_BOTH: begin  // mult, multu
					hi <= productHi;
					lo <= product;
				end
				exePkg::HILO_HI: hi <= cmd.a; // mthi
				exePkg::HILO_LO: lo <= cmd.a; // mtlo
				default: ;                    // Everything else including mul
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/resultReg.sv */
`timescale 1ns/10ps
`default_nettype none

module resultReg (
	input  wire logic          clk,
	input  wire logic          arstN,
	input  wire logic          inValid,
	output logic               inReady,
	output logic               accept,   // Input transfer this cycle
	input  wire exePkg::word_t resultIn,
	input  wire logic          zeroIn,
	output logic               outValid,
	input  wire logic          outReady,
	output exePkg::word_t      result,
	output logic               zero
);

	////////////////////
	// Handshake

	// Room when empty or drained this same edge
	assign inReady = !outValid || outReady;
	assign accept  = inValid && inReady;

	// One-entry stage
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			result   <= '0;   // Outputs read zero after reset
			zero     <= 1'b0;
		end else if (accept) begin
			outValid <= 1'b1;     // Replaces any entry being taken
			result   <= resultIn;
			zero     <= zeroIn;
		end else if (outReady) begin
			outValid <= 1'b0;     // Taken with nothing new behind it
		end
	end

endmodule

`default_nettype wire

/* logic/exeUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module exeUnit (
	input  wire logic          clk,
	input  wire logic          arstN,
	input  wire logic          inValid,
	output logic               inReady,
	input  wire exePkg::word_t instr,
	input  wire exePkg::word_t rsVal,
	input  wire exePkg::word_t rtVal,
	output logic               outValid,
	input  wire logic          outReady,
	output exePkg::word_t      result,
	output logic               zero
);

	exePkg::word_t hi;
	exePkg::word_t lo;
	exePkg::word_t aluResult;  // Also the low product word
	exePkg::word_t aluHi;
	logic          aluZero;
	logic          accept;

	aluCmdIf cmdBus ();

	////////////////////
	// Combinational decode and execute
	instrDecoder decoder (
		.instr (instr),
		.rsVal (rsVal),
		.rtVal (rtVal),
		.hi    (hi),
		.lo    (lo),
		.cmd   (cmdBus.decoder)
	);

	alu32 alu (
		.cmd      (cmdBus.alu),
		.result   (aluResult),
		.hiResult (aluHi),
		.zero     (aluZero)
	);

	// State updated on accept
	hiLoRegs hiLo (
		.clk       (clk),
		.arstN     (arstN),
		.accept    (accept),
		.cmd       (cmdBus.hilo),
		.product   (aluResult),
		.productHi (aluHi),
		.hi        (hi),
		.lo        (lo)
	);

	resultReg outStage (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.accept   (accept),
		.resultIn (aluResult),
		.zeroIn   (aluZero),
		.outValid (outValid),
		.outReady (outReady),
		.result   (result),
		.zero     (zero)
	);

endmodule

`default_nettype wire

/* sim/exeUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module exeUnitTb;

	localparam int NUM_TESTS   = 35;
	localparam int CLK_NS      = 100;
	localparam int WATCHDOG_NS = (NUM_TESTS * 20 + 8) * CLK_NS;

	logic          clk;
	logic          arstN;
	logic          inValid;
	logic          inReady;
	exePkg::word_t instr;
	exePkg::word_t rsVal;
	exePkg::word_t rtVal;
	logic          outValid;
	logic          outReady;
	exePkg::word_t result;
	logic          zero;

	// Five words per test in file column order
	logic [31:0]   vecMem [0:NUM_TESTS*5-1];

	// Scoreboard with one entry per accepted instruction
	exePkg::word_t expResQ [$];
	logic          expZeroQ [$];
	int            idxQ [$];

	int            seed = 32'hc214_e67d;
	int            idx;        // Next vector to offer
	int            doneCount;  // Results seen
	int            passCount;
	int            errCount;
	int            testIdx;
	logic          testBad;
	logic          inFire;
	logic          outFire;
	logic          stalled;    // Output held back last cycle
	exePkg::word_t heldRes;
	logic          heldZero;

	exeUnit dut (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.instr    (instr),
		.rsVal    (rsVal),
		.rtVal    (rtVal),
		.outValid (outValid),
		.outReady (outReady),
		.result   (result),
		.zero     (zero)
	);

	////////////////////
	// Compare tasks

	task automatic checkWord(input exePkg::word_t got, input exePkg::word_t exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			errCount++;
			testBad = 1'b1;
		end
	endtask

	task automatic checkZero(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
			errCount++;
			testBad = 1'b1;
		end
	endtask

	// Reset values and an empty output stage
	task automatic checkIdle(input string when);
		checkZero(outValid, 1'b0, {"outValid ", when});
		checkWord(result, '0, {"result ", when});
		checkZero(zero, 1'b0, {"zero ", when});
		checkZero(inReady, 1'b1, {"inReady ", when});
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// Ends a stuck run
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////
	// Stimulus and scoreboard
	initial begin
		arstN     = 1'b0;
		inValid   = 1'b0;
		instr     = '0;
		rsVal     = '0;
		rtVal     = '0;
		outReady  = 1'b0;
		idx       = 0;
		doneCount = 0;
		passCount = 0;
		errCount  = 0;
		testBad   = 1'b0;
		inFire    = 1'b0;
		outFire   = 1'b0;
		stalled   = 1'b0;
		heldRes   = '0;
		heldZero  = 1'b0;
		$readmemh("sim/exeUnit_tests.txt", vecMem);

		repeat (7) begin
			@(negedge clk);
			#1 checkIdle("in reset");
		end
		@(negedge clk);
		arstN = 1'b1;
		#1 checkIdle("after reset");
		$display("test reset: %s", testBad ? "mismatch" : "passed");
		testBad = 1'b0;

		while (doneCount < NUM_TESTS) begin
			@(negedge clk);
			if (inFire)
				inValid = 1'b0;  // Taken at the last edge
			if (!inValid && idx < NUM_TESTS && ($random(seed) & 3) != 0) begin
				instr   = vecMem[idx*5];
				rsVal   = vecMem[idx*5+1];
				rtVal   = vecMem[idx*5+2];
				inValid = 1'b1;
			end
			outReady = ($random(seed) & 1) != 0;
			#1;

			// Stalled output must not move
			if (stalled) begin
				checkZero(outValid, 1'b1, "outValid under stall");
				checkWord(result, heldRes, "result under stall");
				checkZero(zero, heldZero, "zero under stall");
			end

			inFire  = inValid && inReady;
			outFire = outValid && outReady;
			if (outFire) begin
				if (expResQ.size() == 0) begin
					$display("An output transfer came with no instruction pending");
					errCount++;
				end else begin
					testIdx = idxQ.pop_front();
					checkWord(result, expResQ.pop_front(), "result");
					checkZero(zero, expZeroQ.pop_front(), "zero");
					$display("test %0d instr %h: %s", testIdx, vecMem[testIdx*5],
						testBad ? "mismatch" : "passed");
					if (!testBad)
						passCount++;
					testBad = 1'b0;
					doneCount++;
				end
			end
			if (inFire) begin  // Pushed after the pop as latency is one cycle
				expResQ.push_back(vecMem[idx*5+3]);
				expZeroQ.push_back(vecMem[idx*5+4][0]);
				idxQ.push_back(idx);
				idx++;
			end
			stalled  = outValid && !outReady;
			heldRes  = result;
			heldZero = zero;
		end

		$display("%0d tests, %0d passed, %0d errors", NUM_TESTS, passCount, errCount);
		if (errCount == 0 && passCount == NUM_TESTS)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/exeUnit_tests.txt */
// instr    rsVal    rtVal    result   zero
// Hex words, one test per line, read in order
00000020 00000005 00000007 0000000c 0 // add
00000021 ffffffff 00000001 00000000 1 // addu wraps to zero
00000022 00000003 00000005 fffffffe 0 // sub
00000024 f0f0f0f0 0ff00ff0 00f000f0 0 // and
00000025 f0000000 0000000f f000000f 0 // or
00000026 12345678 12345678 00000000 1 // xor
00000027 0000ffff ff000000 00ff0000 0 // nor
2000fffe 00000010 00000000 0000000e 0 // addi -2
30008f0f ffffffff 00000000 00008f0f 0 // andi zero-extended
0000002a ffffffff 00000001 00000001 0 // slt -1 < 1
0000002b ffffffff 00000001 00000000 1 // sltu
00000000 00000000 80000001 80000001 0 // sll 0
000007c0 00000000 00000003 80000000 0 // sll 31
00000042 00000000 80000000 40000000 0 // srl 1
000007c3 00000000 80000000 ffffffff 0 // sra 31
00200042 00000000 00000001 80000000 0 // rotr 1
00200002 00000000 12345678 12345678 0 // rotr 0
00000004 00000020 ffffffff 00000000 1 // sllv 32
00000006 0000001f 80000000 00000001 0 // srlv 31
00000007 00000040 80000000 ffffffff 0 // srav 64
00000046 00000004 12345678 81234567 0 // rotrv 4
7c000420 00000000 00000080 ffffff80 0 // seb
7c000620 00000000 12347fff 00007fff 0 // seh
00000018 fffffffe 00000003 fffffffa 0 // mult -2 * 3
00000010 00000000 00000000 ffffffff 0 // mfhi
00000012 00000000 00000000 fffffffa 0 // mflo
00000019 ffffffff 00000002 fffffffe 0 // multu
00000010 00000000 00000000 00000001 0 // mfhi
00000012 00000000 00000000 fffffffe 0 // mflo
00000011 13572468 00000000 13572468 0 // mthi
00000013 24681357 00000000 24681357 0 // mtlo
70000002 00010000 00010000 00000000 1 // mul, low word only
00000010 00000000 00000000 13572468 0 // mfhi after mul
00000012 00000000 00000000 24681357 0 // mflo after mul
fc000000 00000000 00000000 00000001 0 // unknown opcode

/* verilog.f */
+incdir+include
logic/exePkg.sv
logic/aluCmdIf.sv
logic/instrDecoder.sv
logic/alu32.sv
logic/hiLoRegs.sv
logic/resultReg.sv
logic/exeUnit.sv
sim/exeUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module exeUnitTb -o exeUnitSim
./obj_dir/exeUnitSim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
